//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;

	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101; // srl and sra, split by funct7
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000; // sub, sra, srai

	typedef enum logic [5:0] {
		RV_INVALID,
		RV_LUI, RV_AUIPC, RV_JAL, RV_JALR,
		RV_BEQ, RV_BNE, RV_BLT, RV_BGE, RV_BLTU, RV_BGEU,
		RV_LB, RV_LH, RV_LW, RV_LBU, RV_LHU,
		RV_SB, RV_SH, RV_SW,
		RV_ADDI, RV_SLTI, RV_SLTIU, RV_XORI, RV_ORI, RV_ANDI,
		RV_SLLI, RV_SRLI, RV_SRAI,
		RV_ADD, RV_SUB, RV_SLL, RV_SLT, RV_SLTU,
		RV_XOR, RV_SRL, RV_SRA, RV_OR, RV_AND
	} rv_op_t;

endpackage

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  byte_off_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WRITE,
		S_HALT
	} ctrl_state_t;

	typedef enum logic [3:0] {
		ADD, SUB,
		SLT, SLTU,
		XOR, OR, AND,
		SLL, SRL, SRA,
		EQ, NE, LT, GE, LTU, GEU
	} alu_op_t;

	// big-endian lanes, offset 0 is the top byte
	localparam strb_t STRB_BYTE = 4'b1000; // shifted right by offset
	localparam strb_t STRB_HALF = 4'b1100;
	localparam strb_t STRB_WORD = 4'b1111;

endpackage

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
	input wire clk,
	input wire core_pkg::word_t instr,
	output core_pkg::reg_idx_t rs1_idx,
	output core_pkg::reg_idx_t rs2_idx,
	output core_pkg::reg_idx_t rd_idx,
	output core_pkg::word_t imm,
	output rv_isa_pkg::rv_op_t op,
	output core_pkg::alu_op_t alu_op,
	output logic use_imm
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	logic r_type, i_type, s_type, b_type, u_type, j_type;
	rv_op_t op_d;
	alu_op_t alu_d;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// format from opcode bits 6..2
	assign r_type = (instr[6:5] == 2'b01 || instr[6:5] == 2'b10) && instr[4:2] == 3'b100;
	assign i_type = (instr[6:5] == 2'b00 && (instr[4:2] == 3'b000 || instr[4:2] == 3'b100 ||
		instr[4:2] == 3'b001)) || (instr[6:5] == 2'b11 && instr[4:2] == 3'b001);
	assign s_type = instr[6:5] == 2'b01 && (instr[4:2] == 3'b000 || instr[4:2] == 3'b001);
	assign b_type = instr[6:5] == 2'b11 && instr[4:2] == 3'b000;
	assign u_type = (instr[6:5] == 2'b01 || instr[6:5] == 2'b00) && instr[4:2] == 3'b101;
	assign j_type = instr[6:5] == 2'b11 && instr[4:2] == 3'b011;

	assign rs1_idx = (r_type | i_type | s_type | b_type) ? instr[19:15] : '0;
	assign rs2_idx = (r_type | s_type | b_type) ? instr[24:20] : '0;

	always_comb begin
		op_d = RV_INVALID;
		case (opcode)
			OP_LUI: op_d = RV_LUI;
			OP_AUIPC: op_d = RV_AUIPC;
			OP_JAL: op_d = RV_JAL;
			OP_JALR: op_d = (funct3 == 3'b000) ? RV_JALR : RV_INVALID;
			OP_BRANCH: case (funct3)
				F3_BEQ: op_d = RV_BEQ;
				F3_BNE: op_d = RV_BNE;
				F3_BLT: op_d = RV_BLT;
				F3_BGE: op_d = RV_BGE;
				F3_BLTU: op_d = RV_BLTU;
				F3_BGEU: op_d = RV_BGEU;
				default: op_d = RV_INVALID;
			endcase
			OP_LOAD: case (funct3)
				F3_B: op_d = RV_LB;
				F3_H: op_d = RV_LH;
				F3_W: op_d = RV_LW;
				F3_BU: op_d = RV_LBU;
				F3_HU: op_d = RV_LHU;
				default: op_d = RV_INVALID;
			endcase
			OP_STORE: case (funct3)
				F3_B: op_d = RV_SB;
				F3_H: op_d = RV_SH;
				F3_W: op_d = RV_SW;
				default: op_d = RV_INVALID;
			endcase
			OP_IMM: case (funct3)
				F3_ADD: op_d = RV_ADDI;
				F3_SLT: op_d = RV_SLTI;
				F3_SLTU: op_d = RV_SLTIU;
				F3_XOR: op_d = RV_XORI;
				F3_OR: op_d = RV_ORI;
				F3_AND: op_d = RV_ANDI;
				F3_SLL: op_d = (funct7 == F7_BASE) ? RV_SLLI : RV_INVALID;
				default: op_d = (funct7 == F7_BASE) ? RV_SRLI :
					(funct7 == F7_ALT) ? RV_SRAI : RV_INVALID;
			endcase
			OP_REG: if (funct7 == F7_BASE) begin
				case (funct3)
					F3_ADD: op_d = RV_ADD;
					F3_SLL: op_d = RV_SLL;
					F3_SLT: op_d = RV_SLT;
					F3_SLTU: op_d = RV_SLTU;
					F3_XOR: op_d = RV_XOR;
					F3_SR: op_d = RV_SRL;
					F3_OR: op_d = RV_OR;
					default: op_d = RV_AND;
				endcase
			end else if (funct7 == F7_ALT) begin
				case (funct3)
					F3_ADD: op_d = RV_SUB;
					F3_SR: op_d = RV_SRA;
					default: op_d = RV_INVALID;
				endcase
			end
			default: op_d = RV_INVALID;
		endcase
	end

	always_comb begin
		case (op_d)
			RV_SUB: alu_d = SUB;
			RV_SLTI, RV_SLT: alu_d = SLT;
			RV_SLTIU, RV_SLTU: alu_d = SLTU;
			RV_XORI, RV_XOR: alu_d = XOR;
			RV_ORI, RV_OR: alu_d = OR;
			RV_ANDI, RV_AND: alu_d = AND;
			RV_SLLI, RV_SLL: alu_d = SLL;
			RV_SRLI, RV_SRL: alu_d = SRL;
			RV_SRAI, RV_SRA: alu_d = SRA;
			RV_BEQ: alu_d = EQ;
			RV_BNE: alu_d = NE;
			RV_BLT: alu_d = LT;
			RV_BGE: alu_d = GE;
			RV_BLTU: alu_d = LTU;
			RV_BGEU: alu_d = GEU;
			default: alu_d = ADD; // also address and link adds
		endcase
	end

	always_ff @(posedge clk) begin
		rd_idx <= (r_type | i_type | u_type | j_type) ? instr[11:7] : '0;
		imm <= i_type ? {{21{instr[31]}}, instr[30:20]} :
			s_type ? {{21{instr[31]}}, instr[30:25], instr[11:7]} :
			b_type ? {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0} :
			u_type ? {instr[31:12], 12'd0} :
			j_type ? {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0} : '0;
		op <= op_d;
		alu_op <= alu_d;
		use_imm <= !(opcode == OP_REG || opcode == OP_BRANCH); // rs2 for r-type and branches
	end

endmodule

`default_nettype wire

//--- int_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module int_regfile (
	input wire clk,
	input wire rstn,
	input wire core_pkg::reg_idx_t rs1_idx,
	input wire core_pkg::reg_idx_t rs2_idx,
	output core_pkg::word_t rs1_data,
	output core_pkg::word_t rs2_data,
	input wire core_pkg::reg_idx_t rd_idx,
	input wire rd_we,
	input wire core_pkg::word_t rd_data
);
	import core_pkg::*;

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_idx != '0) begin
			regs[rd_idx] <= rd_data;
		end
	end

	always_ff @(posedge clk) begin
		rs1_data <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
		rs2_data <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
	end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire clk,
	input wire rstn,
	input wire core_pkg::word_t src1,
	input wire core_pkg::word_t src2,
	input wire core_pkg::alu_op_t alu_op,
	output core_pkg::word_t result
);
	import core_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	word_t result_d;

	assign shamt = src2[4:0];
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;

	always_comb begin
		case (alu_op)
			ADD: result_d = src1 + src2;
			SUB: result_d = src1 - src2;
			SLT: result_d = {31'd0, lt_s};
			SLTU: result_d = {31'd0, lt_u};
			XOR: result_d = src1 ^ src2;
			OR: result_d = src1 | src2;
			AND: result_d = src1 & src2;
			SLL: result_d = src1 << shamt;
			SRL: result_d = src1 >> shamt;
			SRA: result_d = $signed(src1) >>> shamt;
			EQ: result_d = {31'd0, src1 == src2}; // branch compares give 0 or 1
			NE: result_d = {31'd0, src1 != src2};
			LT: result_d = {31'd0, lt_s};
			GE: result_d = {31'd0, !lt_s};
			LTU: result_d = {31'd0, lt_u};
			default: result_d = {31'd0, !lt_u}; // geu
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			result <= result_d;
		end
	end

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu (
	input wire clk,
	input wire rstn,
	input wire start,
	input wire rv_isa_pkg::rv_op_t op,
	input wire core_pkg::word_t addr,
	input wire core_pkg::word_t store_data,
	output core_pkg::word_t load_data,
	output logic done,
	output logic misaligned,
	output core_pkg::word_t araddr,
	output logic arvalid,
	input wire arready,
	input wire core_pkg::word_t rdata,
	input wire rvalid,
	output logic rready,
	output core_pkg::word_t awaddr,
	output logic awvalid,
	input wire awready,
	output core_pkg::word_t wdata,
	output core_pkg::strb_t wstrb,
	output logic wvalid,
	input wire wready,
	input wire bvalid,
	output logic bready
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	typedef enum logic [2:0] {
		L_IDLE,
		L_AR,
		L_R,
		L_W,
		L_B
	} lsu_state_t;

	lsu_state_t state;
	byte_off_t off;
	logic is_store, is_half, is_word, bad_align;
	strb_t strb_d;
	word_t wdata_d;
	word_t rshift;
	word_t load_d;

	assign off = addr[1:0];
	assign is_store = op inside {RV_SB, RV_SH, RV_SW};
	assign is_half = op inside {RV_LH, RV_LHU, RV_SH};
	assign is_word = op inside {RV_LW, RV_SW};
	assign bad_align = is_word ? (off != 2'd0) : is_half ? off[0] : 1'b0;

	// store lane placement, offset 0 in bits 31..24
	always_comb begin
		case (op)
			RV_SB: begin
				strb_d = STRB_BYTE >> off;
				wdata_d = {store_data[7:0], 24'd0} >> {off, 3'b000};
			end
			RV_SH: begin
				strb_d = STRB_HALF >> off;
				wdata_d = {store_data[15:0], 16'd0} >> {off, 3'b000};
			end
			default: begin
				strb_d = STRB_WORD;
				wdata_d = store_data;
			end
		endcase
	end

	assign rshift = rdata << {off, 3'b000}; // selected lane moved to the top
	always_comb begin
		case (op)
			RV_LB: load_d = {{24{rshift[31]}}, rshift[31:24]};
			RV_LBU: load_d = {24'd0, rshift[31:24]};
			RV_LH: load_d = {{16{rshift[31]}}, rshift[31:16]};
			RV_LHU: load_d = {16'd0, rshift[31:16]};
			default: load_d = rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= L_IDLE;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			done <= 1'b0;
			misaligned <= 1'b0;
		end else begin
			done <= 1'b0;
			misaligned <= 1'b0;
			case (state)
				L_IDLE: if (start) begin
					if (bad_align) begin
						done <= 1'b1; // no bus traffic
						misaligned <= 1'b1;
					end else if (is_store) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= L_W;
					end else begin
						arvalid <= 1'b1;
						state <= L_AR;
					end
				end
				L_AR: if (arready) begin
					arvalid <= 1'b0;
					rready <= 1'b1;
					state <= L_R;
				end
				L_R: if (rvalid) begin
					rready <= 1'b0;
					done <= 1'b1;
					state <= L_IDLE;
				end
				L_W: begin
					if (awready) begin
						awvalid <= 1'b0;
					end
					if (wready) begin
						wvalid <= 1'b0;
					end
					if (!awvalid && !wvalid) begin
						bready <= 1'b1;
						state <= L_B;
					end
				end
				default: if (bvalid) begin
					bready <= 1'b0;
					done <= 1'b1;
					state <= L_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == L_IDLE && start) begin
			araddr <= {addr[31:2], 2'b00};
			awaddr <= {addr[31:2], 2'b00};
			wdata <= wdata_d;
			wstrb <= strb_d;
		end
		if (state == L_R && rvalid) begin
			load_data <= load_d;
		end
	end

endmodule

`default_nettype wire

//--- core.sv
`timescale 1ns/100ps
`default_nettype none

module core #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input wire clk,
	input wire rstn,
	output wire core_pkg::word_t araddr,
	output wire arvalid,
	input wire arready,
	input wire core_pkg::word_t rdata,
	input wire rvalid,
	output wire rready,
	output wire core_pkg::word_t awaddr,
	output wire awvalid,
	input wire awready,
	output wire core_pkg::word_t wdata,
	output wire core_pkg::strb_t wstrb,
	output wire wvalid,
	input wire wready,
	input wire bvalid,
	output wire bready,
	output wire halted
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	ctrl_state_t state;
	word_t pc;
	word_t instr;
	word_t mem_addr;
	logic lsu_pend;

	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	reg_idx_t rd_idx;
	word_t imm;
	rv_op_t op;
	alu_op_t alu_op;
	logic use_imm;
	word_t rs1_data;
	word_t rs2_data;
	word_t alu_src2;
	word_t alu_result;
	word_t wb_data;
	word_t next_pc;
	word_t load_data;
	word_t lsu_addr;
	rv_op_t lsu_op;
	logic rd_we, lsu_start, lsu_done, lsu_misaligned;
	logic is_mem, is_store, is_branch;

	assign is_store = op inside {RV_SB, RV_SH, RV_SW};
	assign is_mem = is_store || (op inside {RV_LB, RV_LH, RV_LW, RV_LBU, RV_LHU});
	assign is_branch = op inside {RV_BEQ, RV_BNE, RV_BLT, RV_BGE, RV_BLTU, RV_BGEU};

	assign alu_src2 = use_imm ? imm : rs2_data;
	assign lsu_op = (state == S_FETCH) ? RV_LW : op; // fetch is a word load of the pc
	assign lsu_addr = (state == S_FETCH) ? pc : mem_addr;
	assign lsu_start = (state == S_FETCH || (state == S_MEM && is_mem)) && !lsu_pend;
	assign rd_we = state == S_WRITE && !is_branch && !is_store;
	assign halted = state == S_HALT;

	always_comb begin
		case (op)
			RV_LUI: wb_data = imm;
			RV_AUIPC: wb_data = pc + imm;
			RV_JAL, RV_JALR: wb_data = pc + 32'd4;
			RV_LB, RV_LH, RV_LW, RV_LBU, RV_LHU: wb_data = load_data;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		case (op)
			RV_JAL: next_pc = pc + imm;
			RV_JALR: next_pc = (rs1_data + imm) & ~32'd1;
			default: next_pc = (is_branch && alu_result != '0) ? pc + imm : pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= S_FETCH;
			pc <= RESET_PC;
			lsu_pend <= 1'b0;
		end else begin
			if (lsu_start) begin
				lsu_pend <= 1'b1;
			end else if (lsu_done) begin
				lsu_pend <= 1'b0;
			end
			case (state)
				S_FETCH: if (lsu_done) begin
					state <= lsu_misaligned ? S_HALT : S_DECODE; // odd pc from a jump
				end
				S_DECODE: state <= S_EXEC;
				S_EXEC: state <= (op == RV_INVALID) ? S_HALT : S_MEM;
				S_MEM: if (!is_mem || lsu_done) begin
					state <= lsu_misaligned ? S_HALT : S_WRITE;
				end
				S_WRITE: begin
					pc <= next_pc;
					state <= S_FETCH;
				end
				default: state <= S_HALT; // stays halted
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH && lsu_done) begin
			instr <= load_data;
		end
		if (state == S_EXEC) begin
			mem_addr <= rs1_data + imm;
		end
	end

	rv_decoder decoder_i (
		.clk(clk),
		.instr(instr),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rd_idx(rd_idx),
		.imm(imm),
		.op(op),
		.alu_op(alu_op),
		.use_imm(use_imm)
	);

	int_regfile regfile_i (
		.clk(clk),
		.rstn(rstn),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rd_idx(rd_idx),
		.rd_we(rd_we),
		.rd_data(wb_data)
	);

	alu alu_i (
		.clk(clk),
		.rstn(rstn),
		.src1(rs1_data),
		.src2(alu_src2),
		.alu_op(alu_op),
		.result(alu_result)
	);

	lsu lsu_i (
		.clk(clk),
		.rstn(rstn),
		.start(lsu_start),
		.op(lsu_op),
		.addr(lsu_addr),
		.store_data(rs2_data),
		.load_data(load_data),
		.done(lsu_done),
		.misaligned(lsu_misaligned),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready)
	);

endmodule

`default_nettype wire

//--- core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module core_sva (
	input wire clk,
	input wire rstn,
	input wire core_pkg::word_t araddr,
	input wire arvalid,
	input wire arready,
	input wire core_pkg::word_t awaddr,
	input wire awvalid,
	input wire awready,
	input wire wvalid,
	input wire bready,
	input wire halted
);
	import core_pkg::*;

	ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before awready");

	b_after_aw: assert property (@(posedge clk) disable iff (!rstn)
		!(bready && awvalid))
		else $error("bready high while awvalid still high");

	quiet_halt: assert property (@(posedge clk) disable iff (!rstn)
		halted |=> !$rose(arvalid) && !$rose(awvalid) && !$rose(wvalid))
		else $error("bus request raised after halted");

endmodule

bind core core_sva sva_i (
	.clk(clk),
	.rstn(rstn),
	.araddr(araddr),
	.arvalid(arvalid),
	.arready(arready),
	.awaddr(awaddr),
	.awvalid(awvalid),
	.awready(awready),
	.wvalid(wvalid),
	.bready(bready),
	.halted(halted)
);

`default_nettype wire

//--- core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int MEM_WORDS = 1024;

	logic clk;
	logic rstn;
	word_t araddr;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic rvalid;
	logic rready;
	word_t awaddr;
	logic awvalid;
	logic awready;
	word_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic halted;

	word_t mem [0:MEM_WORDS-1];
	word_t exp_addr [$];
	strb_t exp_strb [$];
	word_t exp_data [$];
	logic [127:0] test_name;
	int errors;
	int checks;
	int limit_cycles;

	core #(.RESET_PC(32'h0000_0000)) core_i (
		.clk(clk),
		.rstn(rstn),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic next_mid; // inputs change 10 ns after the edge
		@(posedge clk);
		#10;
	endtask

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error: test %0s %0s expected %h actual %h", test_name, what, expected,
				actual);
		end
	endtask

	task automatic compare_store(input word_t addr, input strb_t strb, input word_t data);
		word_t ea;
		strb_t es;
		word_t ed;
		word_t mask;
		if (exp_addr.size() == 0) begin
			errors++;
			$display("error: test %0s wrote %h to address %h when no store was expected",
				test_name, data, addr);
		end else begin
			ea = exp_addr.pop_front();
			es = exp_strb.pop_front();
			ed = exp_data.pop_front();
			mask = {{8{es[3]}}, {8{es[2]}}, {8{es[1]}}, {8{es[0]}}}; // only enabled lanes
			check_value("address", ea, addr);
			check_value("strobe", {28'd0, es}, {28'd0, strb});
			check_value("data", ed & mask, data & mask);
		end
	endtask

	task automatic answer_reads;
		word_t a;
		forever begin
			next_mid();
			if (rstn && arvalid) begin
				repeat ($urandom_range(3, 0)) next_mid();
				a = araddr;
				arready = 1'b1;
				next_mid();
				arready = 1'b0;
				repeat ($urandom_range(3, 0)) next_mid();
				rdata = mem[a[11:2]];
				rvalid = 1'b1;
				while (!rready) next_mid();
				next_mid();
				rvalid = 1'b0;
			end
		end
	endtask

	task automatic accept_writes;
		int aw_delay;
		int w_delay;
		int n;
		word_t a;
		word_t d;
		strb_t s;
		forever begin
			next_mid();
			if (rstn && awvalid) begin
				aw_delay = $urandom_range(3, 0);
				w_delay = $urandom_range(3, 0);
				n = 0;
				a = awaddr;
				d = wdata;
				s = wstrb;
				while (awvalid || wvalid) begin
					awready = awvalid && n >= aw_delay;
					wready = wvalid && n >= w_delay;
					next_mid();
					n++;
				end
				awready = 1'b0;
				wready = 1'b0;
				for (int i = 0; i < 4; i++) begin
					if (s[i]) begin
						mem[a[11:2]][8*i +: 8] = d[8*i +: 8]; // strobe bit 3 is bits 31..24
					end
				end
				compare_store(a, s, d);
				repeat ($urandom_range(3, 0)) next_mid();
				bvalid = 1'b1;
				while (!bready) next_mid();
				next_mid();
				bvalid = 1'b0;
			end
		end
	endtask

	task automatic count_words(output int total);
		int fd;
		int code;
		int n;
		word_t a;
		logic [127:0] tok;
		logic [8*200-1:0] line;
		total = 0;
		fd = $fopen("core_input.txt", "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					code = $fgets(line, fd);
				end else if (tok == "w") begin
					code = $fscanf(fd, "%h %d", a, n);
					total += n;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test;
		next_mid();
		rstn = 1'b0;
		repeat (8) next_mid();
		rstn = 1'b1;
		while (!halted) next_mid();
		repeat (20) next_mid(); // any late write shows up as unexpected
		if (exp_addr.size() != 0) begin
			errors++;
			$display("error: test %0s halted with %0d expected stores never written",
				test_name, exp_addr.size());
		end
		$display("test %0s finished", test_name);
	endtask

	task automatic process_records(input int fd);
		int code;
		int n;
		word_t a;
		word_t w;
		strb_t s;
		logic [127:0] tok;
		logic [8*200-1:0] line;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				code = $fgets(line, fd);
			end else if (tok == "t") begin
				code = $fscanf(fd, "%s", test_name);
				for (int i = 0; i < MEM_WORDS; i++) begin
					mem[i] = '0;
				end
				exp_addr.delete();
				exp_strb.delete();
				exp_data.delete();
			end else if (tok == "w") begin
				code = $fscanf(fd, "%h %d", a, n);
				for (int i = 0; i < n; i++) begin
					code = $fscanf(fd, "%h", w);
					mem[(a >> 2) + i] = w;
				end
			end else if (tok == "e") begin
				code = $fscanf(fd, "%h %b %h", a, s, w);
				exp_addr.push_back(a);
				exp_strb.push_back(s);
				exp_data.push_back(w);
			end else if (tok == "r") begin
				run_test();
			end else begin
				errors++;
				$display("error: unknown record %0s in core_input.txt", tok);
			end
		end
		$fclose(fd);
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", limit_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		int seed;
		int fd;
		int total;
		seed = 63533;
		void'($urandom(seed));
		rstn = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		errors = 0;
		checks = 0;
		limit_cycles = 0;
		test_name = "none";
		fork
			answer_reads();
			accept_writes();
		join_none
		count_words(total);
		limit_cycles = total * 200 + 1000;
		fd = $fopen("core_input.txt", "r");
		if (fd == 0) begin
			$display("error: core_input.txt could not be opened");
			$display("Some tests failed");
			$finish;
		end else begin
			process_records(fd);
			$display("%0d checks, %0d errors", checks, errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- files.f
rv_isa_pkg.sv
core_pkg.sv
rv_decoder.sv
int_regfile.sv
alu.sv
lsu.sv
core.sv
core_sva.sv
core_tb.sv

//--- core_input.txt
# t test_name | w word_address_hex word_count then words | r runs the test
# e store_address_hex strobe_binary data_hex, in the order the stores happen
t alu
w 000 31
ff900093 00300113 002081b3 40208233
4020d2b3 0020d333 002093b3 0020a433
0020b4b3 0f00c513 10016593 07f0f613
4020d693 00411713 01c0d793 00513813
10302023 10402223 10502423 10602623
10702823 10802a23 10902c23 10a02e23
12b02023 12c02223 12d02423 12e02623
12f02823 13002a23 00000000
e 100 1111 fffffffc
e 104 1111 fffffff6
e 108 1111 ffffffff
e 10c 1111 1fffffff
e 110 1111 ffffffc8
e 114 1111 00000001
e 118 1111 00000000
e 11c 1111 ffffff09
e 120 1111 00000103
e 124 1111 00000079
e 128 1111 fffffffe
e 12c 1111 00000030
e 130 1111 0000000f
e 134 1111 00000001
r
t branch
w 000 42
fff00093 00100113 05100193 0bd00f93
00108463 1ff02823 00208463 10302023
00118193 00209463 1ff02823 00109463
10302223 00118193 0020c463 1ff02823
00114463 10302423 00118193 00115463
1ff02823 0020d463 10302623 00118193
00116463 1ff02823 0020e463 10302823
00118193 0020f463 1ff02823 00117463
10302a23 0080026f 1ff02823 10402c23
0a000393 00038367 1ff02823 1ff02823
10602e23 00000000
e 100 1111 00000051
e 104 1111 00000052
e 108 1111 00000053
e 10c 1111 00000054
e 110 1111 00000055
e 114 1111 00000056
e 118 1111 00000088
e 11c 1111 00000098
r
t upper
w 000 9
123450b7 00010117 fedcb1b7 fffff217
10102023 10202223 10302423 10402623
00000000
e 100 1111 12345000
e 104 1111 00010004
e 108 1111 fedcb000
e 10c 1111 fffff00c
r
t load
w 200 1
80f17f02
w 000 25
20000083 20100103 20200183 20300203
20004283 20104303 20204383 20304403
20001483 20201503 20005583 20205603
10102023 10202223 10302423 10402623
10502823 10602a23 10702c23 10802e23
12902023 12a02223 12b02423 12c02623
00000000
e 100 1111 ffffff80
e 104 1111 fffffff1
e 108 1111 0000007f
e 10c 1111 00000002
e 110 1111 00000080
e 114 1111 000000f1
e 118 1111 0000007f
e 11c 1111 00000002
e 120 1111 ffff80f1
e 124 1111 00007f02
e 128 1111 000080f1
e 12c 1111 00007f02
r
t store
w 000 9
123450b7 67808093 10100023 101002a3
10100523 101007a3 10101823 10101b23
00000000
e 100 1000 78000000
e 104 0100 00780000
e 108 0010 00007800
e 10c 0001 00000078
e 110 1100 56780000
e 114 0011 00005678
r
t misaligned
w 000 5
05500093 10102023 10202103 10102223
00000000
e 100 1111 00000055
r
t zero_instr
w 000 4
06600093 10102023 00000000 10102223
e 100 1111 00000066
r
